//--- sources.f
+incdir+source
source/gpuPkg.sv
source/syncFifo.sv
source/gpuRegisters.sv
source/cmdParser.sv
source/vertexSort.sv
source/gpuFront.sv
dv/clockGen.sv
dv/tbGpuFront.sv

//--- Bender.yml
package:
  name: gpu_front

export_include_dirs:
  - source

sources:
  - source/gpuPkg.sv
  - source/syncFifo.sv
  - source/gpuRegisters.sv
  - source/cmdParser.sv
  - source/vertexSort.sv
  - source/gpuFront.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/tbGpuFront.sv

//--- dv/tbGpuFront.sv
`timescale 1ns/1ns

module tbGpuFront;
	import gpuPkg::*;

	localparam int waitLimit = 200;		// Cycles allowed per wait
	localparam logic [31:0] statusReset = 32'h1480_2000;

	logic			clk;
	logic			rstGPU;
	cpuBus_t		cpu;
	logic			ack;
	logic			irq;
	logic [31:0]	cpuDataOut;
	logic			primValid;
	logic			primReady;
	triPrimitive_t	prim;

	integer			seed;
	int				checkCount;
	int				errorCount;
	int				timeoutCount;
	logic [31:0]	expStatus;			// Expected status word
	triPrimitive_t	expQueue [$];		// Triangles in send order

	clockGen clkGen (
		.clk	(clk),
		.rstGPU	(rstGPU)
	);

	gpuFront dut (
		.clk		(clk),
		.rstGPU		(rstGPU),
		.cpu		(cpu),
		.ack		(ack),
		.irq		(irq),
		.cpuDataOut	(cpuDataOut),
		.primValid	(primValid),
		.primReady	(primReady),
		.prim		(prim)
	);

	// ------------------------------
	// Checking and bus helpers
	// ------------------------------
	task automatic checkValue(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timed out waiting for %s", what);
	endtask

	task automatic busWrite(input logic a2, input logic [31:0] data);
		@(posedge clk);
		cpu <= '{sel: 1'b1, adrA2: a2, write: 1'b1, read: 1'b0, dataIn: data};
		@(posedge clk);		// Write taken on this edge
		cpu <= '0;
	endtask

	// GP0 word, sent only once the FIFO has room
	task automatic gp0Write(input logic [31:0] data);
		int n;
		n = 0;
		@(negedge clk);
		while (!ack && n < waitLimit) begin
			@(negedge clk);
			n++;
		end
		if (!ack) reportTimeout("room in the command FIFO");
		else busWrite(1'b0, data);
	endtask

	task automatic readStatus(output logic [31:0] value);
		@(posedge clk);
		cpu <= '{sel: 1'b1, adrA2: 1'b1, write: 1'b0, read: 1'b1, dataIn: 32'd0};
		@(negedge clk);
		value = cpuDataOut;
		@(posedge clk);
		cpu <= '0;
	endtask

	// Status must keep its old value until it switches to the new one
	task automatic waitStatus(input string name, input logic [31:0] oldValue,
			input logic [31:0] newValue);
		logic [31:0] value;
		int n;
		n = 0;
		@(posedge clk);
		cpu <= '{sel: 1'b1, adrA2: 1'b1, write: 1'b0, read: 1'b1, dataIn: 32'd0};
		@(negedge clk);
		value = cpuDataOut;
		while (value === oldValue && oldValue !== newValue && n < waitLimit) begin
			@(negedge clk);
			value = cpuDataOut;
			n++;
		end
		if (value === oldValue && oldValue !== newValue) reportTimeout(name);
		else checkValue(name, newValue, value);
		@(posedge clk);
		cpu <= '0;
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] applyAttr(input logic [31:0] status, input logic [31:0] word);
		logic [31:0] s;
		s = status;
		if (word[31:24] == 8'hE1) begin
			s[10:0]	= word[10:0];		// Page, blend, depth, dither, draw to display
			s[15]	= word[11];			// Texture disable
		end else if (word[31:24] == 8'hE6) begin
			s[12:11] = word[1:0];		// Check mask, force mask
		end
		return s;
	endfunction

	// 8-bit channel onto 0..256
	function automatic logic [8:0] widenChannel(input logic [7:0] c);
		if (c >= 8'h80) return {1'b0, c} + 9'd1;
		return {1'b0, c};
	endfunction

	function automatic vertex_t placeVertex(input logic [31:0] w, input int offX, input int offY);
		vertex_t v;
		int x;
		int y;
		x = $signed(w[10:0]) + offX;	// Never wraps, both inputs are 11 bits
		y = $signed(w[26:16]) + offY;
		v.x = x[11:0];
		v.y = y[11:0];
		return v;
	endfunction

	function automatic triPrimitive_t expectTriangle(input logic [31:0] cmd,
			input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] w2,
			input int offX, input int offY);
		triPrimitive_t p;
		vertex_t v [3];
		vertex_t tmp;
		int i;
		int j;
		v[0] = placeVertex(w0, offX, offY);
		v[1] = placeVertex(w1, offX, offY);
		v[2] = placeVertex(w2, offX, offY);
		for (i = 0; i < 2; i++) begin
			for (j = 0; j < 2 - i; j++) begin
				if ($signed(v[j + 1].y) < $signed(v[j].y)) begin	// Strict, equal Y stays put
					tmp			= v[j];
					v[j]		= v[j + 1];
					v[j + 1]	= tmp;
				end
			end
		end
		p.top			= v[0];
		p.middle		= v[1];
		p.bottom		= v[2];
		p.color.r		= widenChannel(cmd[7:0]);
		p.color.g		= widenChannel(cmd[15:8]);
		p.color.b		= widenChannel(cmd[23:16]);
		p.semiTransp	= cmd[25];
		return p;
	endfunction

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic testResetDefaults();
		logic [31:0] status;
		readStatus(status);
		checkValue("reset status", statusReset, status);
		@(negedge clk);
		checkValue("reset irq", 1'b0, irq);
		checkValue("reset primValid", 1'b0, primValid);
		checkValue("reset ack", 1'b1, ack);
	endtask

	task automatic testGp1Control();
		logic [31:0] status;
		logic [7:0] mode;
		int i;
		busWrite(1'b1, 32'h0300_0000);		// Display on
		busWrite(1'b1, 32'h0400_0002);		// DMA direction 2
		readStatus(status);
		checkValue("display enable", 1'b0, status[23]);
		checkValue("DMA direction", 2'd2, status[30:29]);
		for (i = 0; i < 2; i++) begin
			mode = (i == 0) ? 8'h2F : 8'h5E;	// 480 lines with and without interlace
			busWrite(1'b1, {8'h08, 16'd0, mode});
			readStatus(status);
			checkValue("display mode", {mode[5], mode[4], mode[3], mode[2] & mode[5],
				mode[1:0], mode[6]}, status[22:16]);
		end
		busWrite(1'b1, 32'h0000_0000);		// Full reset
		readStatus(status);
		checkValue("status after GP1 reset", statusReset, status);
		expStatus = statusReset;
	endtask

	task automatic sendAttr(input string name, input logic [31:0] word);
		logic [31:0] newStatus;
		newStatus = applyAttr(expStatus, word);
		gp0Write(word);
		waitStatus(name, expStatus, newStatus);
		expStatus = newStatus;
	endtask

	task automatic testRenderAttr();
		logic [31:0] word;
		int i;
		sendAttr("texture page", {8'hE1, 10'd0, 14'h0B5A});
		sendAttr("mask bits", {8'hE6, 22'd0, 2'b01});
		for (i = 0; i < 2; i++) begin
			word = $random(seed);
			word[31:24] = ($random(seed) & 1) ? 8'hE6 : 8'hE1;
			sendAttr($sformatf("random attribute %0d", i), word);
		end
	endtask

	task automatic testIrq();
		logic [31:0] status;
		int n;
		gp0Write(32'h1F00_0000);
		n = 0;
		@(negedge clk);
		while (!irq && n < waitLimit) begin
			@(negedge clk);
			n++;
		end
		if (!irq) reportTimeout("irq after GP0 1Fh");
		readStatus(status);
		checkValue("irq status bit set", 1'b1, status[24]);
		busWrite(1'b1, 32'h0200_0000);		// Acknowledge
		readStatus(status);
		checkValue("irq status bit clear", 1'b0, status[24]);
		@(negedge clk);
		checkValue("irq pin clear", 1'b0, irq);
	endtask

	task automatic testTriangles();
		logic [31:0] cmd;
		logic [31:0] words [3];
		triPrimitive_t want;
		int offX;
		int offY;
		int t;
		int k;
		int n;
		@(posedge clk);
		primReady <= 1'b0;
		offX = -(($random(seed) & 511) + 1);	// Negative X offset
		offY = ($random(seed) & 511) + 1;
		gp0Write({8'hE5, 2'b00, offY[10:0], offX[10:0]});
		for (t = 0; t < 4; t++) begin
			cmd = $random(seed);
			cmd[31:26] = 6'b001000;				// 20h..23h, low bits random
			for (k = 0; k < 3; k++) begin
				words[k] = $random(seed);
				if (t[0]) words[k][26:18] = '0;	// Tiny Y range makes ties
			end
			expQueue.push_back(expectTriangle(cmd, words[0], words[1], words[2], offX, offY));
			gp0Write(cmd);
			for (k = 0; k < 3; k++) gp0Write(words[k]);
		end
		// Pad the stalled FIFO until ack drops
		n = 0;
		@(negedge clk);
		while (ack && n < 16) begin
			busWrite(1'b0, 32'hE600_0000);
			n++;
			@(negedge clk);
		end
		checkValue("ack low under back-pressure", 1'b0, ack);
		@(posedge clk);
		primReady <= 1'b1;
		n = 0;
		t = 0;
		while (expQueue.size() > 0 && n < waitLimit) begin
			@(negedge clk);
			n++;
			if (primValid) begin			// Popped on the next edge
				want = expQueue.pop_front();
				checkValue($sformatf("triangle %0d", t), want, prim);
				t++;
			end
		end
		if (expQueue.size() > 0) reportTimeout("the queued triangles");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int n;
		seed			= 32'ha57e;
		checkCount		= 0;
		errorCount		= 0;
		timeoutCount	= 0;
		expStatus		= statusReset;
		cpu				= '0;
		primReady		= 1'b0;
		n = 0;
		@(negedge clk);
		while (rstGPU !== 1'b0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (rstGPU !== 1'b0) reportTimeout("reset release");
		testResetDefaults();
		testGp1Control();
		testRenderAttr();
		testIrq();
		testTriangles();
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ns

module clockGen (
	output logic	clk,
	output logic	rstGPU
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	// Reset held for the first 16 rising edges
	initial begin
		rstGPU = 1'b1;
		repeat (16) @(posedge clk);
		rstGPU <= 1'b0;
	end

endmodule

//--- source/gpuFront.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module gpuFront (
	input  logic					clk,
	input  logic					rstGPU,
	input  gpuPkg::cpuBus_t			cpu,
	output logic					ack,		// Command FIFO not full
	output logic					irq,
	output logic [31:0]				cpuDataOut,
	output logic					primValid,
	input  logic					primReady,
	output gpuPkg::triPrimitive_t	prim
);
	import gpuPkg::*;

	logic			gp0Push;
	logic			cmdFull;
	logic			cmdEmpty;
	logic			cmdPop;
	logic [31:0]	cmdWord;
	logic [31:0]	statusWord;
	logic			softReset;
	logic			cmdReset;
	logic			fullReset;
	logic [5:0]		attrLoad;
	logic			setIrq;
	logic			primFull;
	logic			primEmpty;
	logic			primPush;
	renderAttr_t	attr;
	loadCtrl_t		load;
	triPrimitive_t	primIn;

	// ------------------------------
	// CPU port
	// ------------------------------
	assign gp0Push		= cpu.sel & cpu.write & ~cpu.adrA2;
	assign ack			= ~cmdFull;
	assign cpuDataOut	= (cpu.sel & cpu.read & cpu.adrA2) ? statusWord : 32'd0;
	assign fullReset	= rstGPU | softReset;

	syncFifo #(
		.payload_t	(logic [31:0]),
		.depthLog2	(`GPU_CMD_FIFO_DEPTH_LOG2)
	) cmdFifo (
		.clk		(clk),
		.rstGPU		(rstGPU),
		.flush		(cmdReset | softReset),	// GP1 00h and 01h both drop queued words
		.push		(gp0Push),
		.pop		(cmdPop),
		.dataIn		(cpu.dataIn),
		.dataOut	(cmdWord),
		.full		(cmdFull),
		.empty		(cmdEmpty)
	);

	gpuRegisters regs (
		.clk		(clk),
		.rstGPU		(rstGPU),
		.cpu		(cpu),
		.cmdWord	(cmdWord),
		.attrLoad	(attrLoad),
		.setIrq		(setIrq),
		.fifoFull	(cmdFull),
		.softReset	(softReset),
		.cmdReset	(cmdReset),
		.attr		(attr),
		.irq		(irq),
		.statusWord	(statusWord)
	);

	cmdParser parser (
		.clk		(clk),
		.rstGPU		(rstGPU),
		.softReset	(softReset),
		.cmdReset	(cmdReset),
		.cmdWord	(cmdWord),
		.fifoEmpty	(cmdEmpty),
		.primFull	(primFull),
		.fifoPop	(cmdPop),
		.attrLoad	(attrLoad),
		.setIrq		(setIrq),
		.load		(load)
	);

	vertexSort sorter (
		.clk		(clk),
		.rstGPU		(fullReset),			// Cancels a push in flight
		.load		(load),
		.cmdWord	(cmdWord),
		.attr		(attr),
		.primPush	(primPush),
		.primOut	(primIn)
	);

	// ------------------------------
	// Primitive output queue
	// ------------------------------
	syncFifo #(
		.payload_t	(triPrimitive_t),
		.depthLog2	(`GPU_PRIM_QUEUE_DEPTH_LOG2)
	) primQueue (
		.clk		(clk),
		.rstGPU		(rstGPU),
		.flush		(softReset),
		.push		(primPush),
		.pop		(primValid & primReady),
		.dataIn		(primIn),
		.dataOut	(prim),
		.full		(primFull),
		.empty		(primEmpty)
	);

	assign primValid = ~primEmpty;

endmodule

//--- source/vertexSort.sv
`timescale 1ns/1ns

module vertexSort (
	input  logic					clk,
	input  logic					rstGPU,
	input  gpuPkg::loadCtrl_t		load,
	input  logic [31:0]				cmdWord,
	input  gpuPkg::renderAttr_t		attr,
	output logic					primPush,
	output gpuPkg::triPrimitive_t	primOut
);
	import gpuPkg::*;

	// 0..255 to 0..256, so 80h gives 81h and FFh gives 100h
	function automatic logic [8:0] expand(input logic [7:0] c);
		return {1'b0, c} + {8'd0, c[7]};
	endfunction

	vertex_t	vtx [3];			// In load order
	vertex_t	newVtx;
	color9_t	color;
	logic		semiTransp;
	logic [1:0]	rank [3];			// Output slot of each vertex
	logic		y1Above0;
	logic		y2Above0;
	logic		y2Above1;

	// Sign extend and add the drawing offset
	assign newVtx.x = {cmdWord[10], cmdWord[10:0]} + {attr.drawOffsetX[10], attr.drawOffsetX};
	assign newVtx.y = {cmdWord[26], cmdWord[26:16]} + {attr.drawOffsetY[10], attr.drawOffsetY};

	always_ff @(posedge clk) begin
		if (load.loadColor) begin
			color.r		<= expand(cmdWord[7:0]);
			color.g		<= expand(cmdWord[15:8]);
			color.b		<= expand(cmdWord[23:16]);
			semiTransp	<= cmdWord[25];				// Command bit 1
		end
		if (load.loadVertex) vtx[load.vertexIndex] <= newVtx;
	end

	always_ff @(posedge clk) begin
		if (rstGPU) primPush <= 1'b0;
		else primPush <= load.issueTri;				// Last vertex is stored by now
	end

	// ------------------------------
	// Stable Y sort
	// ------------------------------
	assign y1Above0	= vtx[1].y < vtx[0].y;			// Strict compare keeps load order on ties
	assign y2Above0	= vtx[2].y < vtx[0].y;
	assign y2Above1	= vtx[2].y < vtx[1].y;

	assign rank[0]	= {1'b0, y1Above0} + {1'b0, y2Above0};
	assign rank[1]	= {1'b0, ~y1Above0} + {1'b0, y2Above1};
	assign rank[2]	= {1'b0, ~y2Above0} + {1'b0, ~y2Above1};

	always_comb begin
		primOut.top		= vtx[0];
		primOut.middle	= vtx[1];
		primOut.bottom	= vtx[2];
		for (int i = 0; i < 3; i++) begin
			case (rank[i])
				2'd0:		primOut.top = vtx[i];
				2'd1:		primOut.middle = vtx[i];
				default:	primOut.bottom = vtx[i];
			endcase
		end
		primOut.color		= color;
		primOut.semiTransp	= semiTransp;
	end

endmodule

//--- source/cmdParser.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module cmdParser (
	input  logic					clk,
	input  logic					rstGPU,
	input  logic					softReset,
	input  logic					cmdReset,
	input  logic [31:0]				cmdWord,
	input  logic					fifoEmpty,
	input  logic					primFull,
	output logic					fifoPop,
	output logic [5:0]				attrLoad,
	output logic					setIrq,
	output gpuPkg::loadCtrl_t		load
);

	typedef enum logic [1:0] {
		sIdle,
		sCommand,		// Decode and pop the command word
		sVertex,		// One vertex word per pop
		sStall			// Primitive queue full before last vertex
	} parseState_t;

	parseState_t	state;
	parseState_t	nextState;
	logic [1:0]		vtxIdx;
	logic [1:0]		nextVtxIdx;
	logic [7:0]		opcode;
	logic			isAttr;
	logic			isIrq;
	logic			isTri;
	logic			lastVertex;
	logic			clear;

	// ------------------------------
	// Opcode classes
	// ------------------------------
	assign opcode	= cmdWord[31:24];
	assign isAttr	= (opcode[7:3] == `GPU_GP0_ATTR_BASE) &&
					  (opcode[2:0] != 3'd0) && (opcode[2:0] != 3'd7);	// E1h..E6h only
	assign isIrq	= (opcode == `GPU_GP0_IRQ);
	assign isTri	= (opcode[7:2] == `GPU_GP0_FLAT_TRI);	// Anything else is a no-op

	assign lastVertex	= (vtxIdx == 2'd2);
	assign clear		= rstGPU | softReset | cmdReset;

	always_ff @(posedge clk) begin
		if (clear) begin
			state	<= sIdle;
			vtxIdx	<= 2'd0;
		end else begin
			state	<= nextState;
			vtxIdx	<= nextVtxIdx;
		end
	end

	// ------------------------------
	// Next state and strobes
	// ------------------------------
	always_comb begin
		nextState	= state;
		nextVtxIdx	= vtxIdx;
		fifoPop		= 1'b0;
		attrLoad	= '0;
		setIrq		= 1'b0;
		load		= '0;
		case (state)
			sIdle: begin
				if (!fifoEmpty) nextState = sCommand;	// Head word is visible next cycle
			end
			sCommand: begin
				nextState	= sIdle;
				fifoPop		= !fifoEmpty;
				if (!fifoEmpty) begin
					if (isAttr) attrLoad = 6'd1 << (opcode[2:0] - 3'd1);
					setIrq = isIrq;
					if (isTri) begin
						load.loadColor	= 1'b1;		// Colour sits in the command word
						nextVtxIdx		= 2'd0;
						nextState		= sVertex;
					end
				end
			end
			sVertex: begin
				if (lastVertex && primFull) begin
					nextState = sStall;				// Hold third vertex back
				end else if (!fifoEmpty) begin
					fifoPop				= 1'b1;
					load.loadVertex		= 1'b1;
					load.vertexIndex	= vtxIdx;
					if (lastVertex) begin
						load.issueTri	= 1'b1;
						nextState		= sIdle;
					end else begin
						nextVtxIdx		= vtxIdx + 2'd1;
					end
				end
			end
			sStall: begin
				if (!primFull) nextState = sVertex;	// Queue drained by one
			end
			default: nextState = sIdle;
		endcase
	end

endmodule

//--- source/gpuRegisters.sv
`timescale 1ns/1ns
`include "gpu_defines.svh"

module gpuRegisters (
	input  logic					clk,
	input  logic					rstGPU,
	input  gpuPkg::cpuBus_t			cpu,
	input  logic [31:0]				cmdWord,	// Head of command FIFO
	input  logic [5:0]				attrLoad,	// One-hot E1h..E6h
	input  logic					setIrq,
	input  logic					fifoFull,
	output logic					softReset,
	output logic					cmdReset,
	output gpuPkg::renderAttr_t		attr,
	output logic					irq,
	output logic [31:0]				statusWord
);
	import gpuPkg::*;

	gpuCtrl_t		ctrl;
	logic			gp1Write;
	logic [7:0]		gp1Op;
	logic			irqAck;
	logic			setDisplay;
	logic			setDmaDir;
	logic			setDispMode;
	logic			clearAll;

	// ------------------------------
	// GP1 decode
	// ------------------------------
	assign gp1Write		= cpu.sel & cpu.write & cpu.adrA2;
	assign gp1Op		= cpu.dataIn[31:24];
	assign softReset	= gp1Write & (gp1Op == `GPU_GP1_RESET);
	assign cmdReset		= gp1Write & (gp1Op == `GPU_GP1_CMD_RESET);
	assign irqAck		= gp1Write & (gp1Op == `GPU_GP1_IRQ_ACK);
	assign setDisplay	= gp1Write & (gp1Op == `GPU_GP1_DISP_ENABLE);
	assign setDmaDir	= gp1Write & (gp1Op == `GPU_GP1_DMA_DIR);
	assign setDispMode	= gp1Write & (gp1Op == `GPU_GP1_DISP_MODE);
	assign clearAll		= rstGPU | softReset;

	// Control register and IRQ flag
	always_ff @(posedge clk) begin
		if (clearAll) begin
			ctrl					<= '0;
			ctrl.displayDisabled	<= 1'b1;	// Display off after reset
			irq						<= 1'b0;
		end else begin
			if (setDisplay) ctrl.displayDisabled <= cpu.dataIn[0];
			if (setDmaDir) ctrl.dmaDirection <= cpu.dataIn[1:0];
			if (setDispMode) begin
				ctrl.horizRes		<= cpu.dataIn[1:0];
				ctrl.verticalRes	<= cpu.dataIn[2] & cpu.dataIn[5];	// 480 needs interlace
				ctrl.videoMode		<= cpu.dataIn[3];
				ctrl.rgb888			<= cpu.dataIn[4];
				ctrl.interlaced		<= cpu.dataIn[5];
				ctrl.horizRes368	<= cpu.dataIn[6];
				ctrl.reverseFlag	<= cpu.dataIn[7];
			end
			if (setIrq) irq <= 1'b1;		// Set beats acknowledge
			else if (irqAck) irq <= 1'b0;
		end
	end

	// ------------------------------
	// Render attributes from GP0
	// ------------------------------
	always_ff @(posedge clk) begin
		if (clearAll) begin
			attr			<= '0;
			attr.drawAreaX1	<= `GPU_DRAW_AREA_MAX;
			attr.drawAreaY1	<= `GPU_DRAW_AREA_MAX;
		end else begin
			if (attrLoad[0]) begin		// E1h texture page
				attr.texPageX		<= cmdWord[3:0];
				attr.texPageY		<= cmdWord[4];
				attr.transparency	<= cmdWord[6:5];
				attr.texFormat		<= cmdWord[8:7];
				attr.dither			<= cmdWord[9];
				attr.drawToDisplay	<= cmdWord[10];
				attr.textureDisable	<= cmdWord[11];
				attr.texFlipX		<= cmdWord[12];
				attr.texFlipY		<= cmdWord[13];
			end
			if (attrLoad[1]) begin		// E2h texture window
				attr.winMaskX	<= cmdWord[4:0];
				attr.winMaskY	<= cmdWord[9:5];
				attr.winOffsetX	<= cmdWord[14:10];
				attr.winOffsetY	<= cmdWord[19:15];
			end
			if (attrLoad[2]) begin		// E3h top left
				attr.drawAreaX0	<= cmdWord[9:0];
				attr.drawAreaY0	<= cmdWord[19:10];
			end
			if (attrLoad[3]) begin		// E4h bottom right
				attr.drawAreaX1	<= cmdWord[9:0];
				attr.drawAreaY1	<= cmdWord[19:10];
			end
			if (attrLoad[4]) begin		// E5h offset
				attr.drawOffsetX	<= cmdWord[10:0];
				attr.drawOffsetY	<= cmdWord[21:11];
			end
			if (attrLoad[5]) begin		// E6h mask bits
				attr.forceMask	<= cmdWord[0];
				attr.checkMask	<= cmdWord[1];
			end
		end
	end

	// Status word, 14802000h after reset
	assign statusWord = {
		1'b0,								// 31 no line parity
		ctrl.dmaDirection,					// 30:29
		~fifoFull,							// 28 ready for DMA block
		1'b0,								// 27 no VRAM read back
		~fifoFull,							// 26 ready for command
		1'b0,								// 25 no DMA request
		irq,								// 24
		ctrl.displayDisabled,				// 23
		ctrl.interlaced,					// 22
		ctrl.rgb888,						// 21
		ctrl.videoMode,						// 20
		ctrl.verticalRes,					// 19
		ctrl.horizRes,						// 18:17
		ctrl.horizRes368,					// 16
		attr.textureDisable,				// 15
		ctrl.reverseFlag,					// 14
		1'b1,								// 13 no video timing, field stays odd
		attr.checkMask,						// 12
		attr.forceMask,						// 11
		attr.drawToDisplay,					// 10
		attr.dither,						// 9
		attr.texFormat,						// 8:7
		attr.transparency,					// 6:5
		attr.texPageY,						// 4
		attr.texPageX						// 3:0
	};

endmodule

//--- source/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
	parameter type payload_t = logic [31:0],
	parameter int depthLog2 = 4
) (
	input  logic		clk,
	input  logic		rstGPU,
	input  logic		flush,		// Drops the whole content
	input  logic		push,
	input  logic		pop,
	input  payload_t	dataIn,
	output payload_t	dataOut,	// Head word, valid while not empty
	output logic		full,
	output logic		empty
);

	localparam int depth = 1 << depthLog2;

	payload_t				mem [depth];
	logic [depthLog2-1:0]	wrPtr;
	logic [depthLog2-1:0]	rdPtr;
	logic [depthLog2:0]		count;		// One extra bit to tell full from empty
	logic					doPush;
	logic					doPop;

	assign doPush	= push & ~full;		// Push on a full FIFO is lost
	assign doPop	= pop & ~empty;

	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (rstGPU | flush) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;	// Wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Both or neither
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= dataIn;
	end

	assign dataOut	= mem[rdPtr];		// First-word fall-through
	assign full		= (count == (depthLog2 + 1)'(depth));
	assign empty	= (count == '0);

endmodule

//--- source/gpuPkg.sv
package gpuPkg;

	// CPU register port, one access per cycle
	typedef struct packed {
		logic			sel;
		logic			adrA2;		// 0 = GP0, 1 = GP1 / status
		logic			write;
		logic			read;
		logic	[31:0]	dataIn;
	} cpuBus_t;

	// State written through GP1
	typedef struct packed {
		logic			displayDisabled;
		logic	[1:0]	dmaDirection;
		logic			interlaced;
		logic			rgb888;
		logic			videoMode;		// 0 NTSC, 1 PAL
		logic			verticalRes;	// 480 lines only when interlaced
		logic	[1:0]	horizRes;
		logic			horizRes368;
		logic			reverseFlag;
	} gpuCtrl_t;

	// ------------------------------
	// Render attributes E1h..E6h
	// ------------------------------
	typedef struct packed {
		logic	[3:0]	texPageX;
		logic			texPageY;
		logic	[1:0]	transparency;
		logic	[1:0]	texFormat;
		logic			dither;
		logic			drawToDisplay;
		logic			textureDisable;
		logic			texFlipX;
		logic			texFlipY;
		logic	[4:0]	winMaskX;
		logic	[4:0]	winMaskY;
		logic	[4:0]	winOffsetX;
		logic	[4:0]	winOffsetY;
		logic	[9:0]	drawAreaX0;
		logic	[9:0]	drawAreaY0;
		logic	[9:0]	drawAreaX1;
		logic	[9:0]	drawAreaY1;
		logic signed [10:0]	drawOffsetX;
		logic signed [10:0]	drawOffsetY;
		logic			forceMask;		// Set bit 15 on write
		logic			checkMask;		// Skip pixels with bit 15 set
	} renderAttr_t;

	typedef logic signed [11:0] coord_t;	// Screen coordinate after offset

	typedef struct packed {
		coord_t			x;
		coord_t			y;
	} vertex_t;

	// 0..256 per channel, 100h is full intensity
	typedef struct packed {
		logic	[8:0]	r;
		logic	[8:0]	g;
		logic	[8:0]	b;
	} color9_t;

	typedef struct packed {
		vertex_t		top;
		vertex_t		middle;
		vertex_t		bottom;
		color9_t		color;
		logic			semiTransp;
	} triPrimitive_t;

	// Parser to vertex stage strobes
	typedef struct packed {
		logic			loadColor;
		logic			loadVertex;
		logic	[1:0]	vertexIndex;
		logic			issueTri;		// Last vertex of the triangle
	} loadCtrl_t;

endpackage

//--- source/gpu_defines.svh
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// ------------------------------
// Queue depths
// ------------------------------
`define GPU_CMD_FIFO_DEPTH_LOG2		4		// 16 command words
`define GPU_PRIM_QUEUE_DEPTH_LOG2	1		// Two queued triangles

// ------------------------------
// GP0 opcodes
// ------------------------------
`define GPU_GP0_IRQ					8'h1F
`define GPU_GP0_ATTR_BASE			5'b11100	// Top bits of E0h..E7h
`define GPU_GP0_FLAT_TRI			6'b001000	// Top bits of 20h..23h

// ------------------------------
// GP1 opcodes
// ------------------------------
`define GPU_GP1_RESET				8'h00
`define GPU_GP1_CMD_RESET			8'h01
`define GPU_GP1_IRQ_ACK				8'h02
`define GPU_GP1_DISP_ENABLE			8'h03
`define GPU_GP1_DMA_DIR				8'h04
`define GPU_GP1_DISP_MODE			8'h08

`define GPU_DRAW_AREA_MAX			10'd1023	// Whole VRAM after reset

`endif
